// ==== common/z80_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Z80 bus types for the memory pager
// the bus is sampled on fclk, and the
// zpos/zneg strobes mark Z80 clock edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package z80_bus_pkg;

	// Z80 bus as seen by the pager, control lines active low
	typedef struct packed
	{
		logic [15:0] za;     // address bus
		logic [7:0]  zd;     // data bus, only valid on writes
		logic        mreq_n; // memory request
		logic        iorq_n; // io request
		logic        rd_n;   // read strobe
		logic        wr_n;   // write strobe
		logic        m1_n;   // opcode fetch / int ack
	} z80_bus_t;

	// z80 clock edge strobes, one fclk cycle wide each
	// zpos marks the rising edge of zclk, zneg the falling one
	typedef struct packed
	{
		logic zpos;
		logic zneg;
	} z80_phase_t;

endpackage

// ==== common/mem_map_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// paging types and constants
// page numbers, window index, xxF7 data
// formats, pentagon-1024 config and
// the per-window mapping and read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_map_pkg;

	typedef logic [7:0] page_t;    // number of a 16k page
	typedef logic [1:0] window_t;  // za[15:14]
	typedef logic       map_sel_t; // 7ffd rom bit picks the map

	// 1m format of the xxF7 byte (xFF7 ports)
	typedef struct packed
	{
		logic       dos_7ffd; // 7ffd bits go into the page
		logic       ramnrom;  // 1 = ram, 0 = rom
		logic [5:0] page_n;   // inverted page, upper bits forced
	} f7_1m_t;

	// xxF7 data byte, decoded per port address bit 11
	typedef union packed
	{
		f7_1m_t mb1; // x FF7 ports
		page_t  mb4; // x 7F7 ports, whole inverted page
	} f7_data_u;

	// pentagon-1024 configuration from 7ffd and eff7
	typedef struct packed
	{
		logic [5:0] pent1m_page;   // page bits of 7ffd
		logic       pent1m_rom;    // 7ffd d4
		logic       pent1m_ram0_0; // ram0 into window 0
		logic       pent1m_1m_on;  // 1m addressing through 7ffd
	} pent_cfg_t;

	// mapping of one window as used by the memory controller
	typedef struct packed
	{
		page_t page;
		logic  romnram; // 1 = rom chip
		logic  valid;   // mapping follows the port map, not a forced case
	} map_t;

	// xxBE read-back of one window
	typedef struct packed
	{
		page_t      page0;
		page_t      page1;
		logic [1:0] dos_7ffd; // per map
		logic [1:0] ramnrom;  // per map
	} pager_rd_t;

	localparam page_t       SERVICE_ROM_PAGE = 8'hFF;
	localparam page_t       NMI_RAM_PAGE     = 8'hFF;
	localparam page_t       RAM0_PAGE        = 8'h00;
	localparam logic [5:0]  DOS_ENTRY_HI     = 6'h3D; // za[13:8] of trdos entry
	localparam int          F7_1M_SEL_BIT    = 11;    // za bit, 1 = 1m format
	localparam int          STALL_CYCLES     = 4;
	localparam logic [7:0]  PORT_F7_LO       = 8'hF7;
	localparam logic [15:0] PORT_7FFD        = 16'h7FFD;
	localparam logic [15:0] PORT_EFF7        = 16'hEFF7;

endpackage

// ==== pager/atm_pager.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// atm style pager for one 16k window
// holds two page maps (chosen by 7ffd rom bit)
// loaded from xxF7 writes, and computes the
// registered page of the window every cycle
// also flags trdos entry and exit fetches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module atm_pager
#(
	parameter mem_map_pkg::window_t window_index = 2'd0
)
(
	input  logic                   fclk,
	input  logic                   reset,

	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::z80_phase_t phase,
	input  mem_map_pkg::pent_cfg_t  cfg,

	input  logic                   f7_wr,   // xxF7 write strobe
	input  mem_map_pkg::f7_data_u  f7_data,

	input  logic                   pager_off, // service rom everywhere
	input  logic                   in_nmi,    // last ram page at 0000
	input  logic                   dos,

	output mem_map_pkg::map_t      map,
	output mem_map_pkg::pager_rd_t rd_back,
	output logic                   dos_turn_on,
	output logic                   dos_turn_off
);

	mem_map_pkg::page_t    pages [2]; // one page per map
	logic [1:0]            ramnrom;   // 1 = ram
	logic [1:0]            dos_7ffd;  // 7ffd bits in ram map, dos bit in rom map

	mem_map_pkg::map_sel_t sel;
	mem_map_pkg::page_t    sel_page;
	mem_map_pkg::map_t     map_next;

	logic                  win_hit;
	logic                  m1_n_reg;   // m1_n at last zpos
	logic                  mreq_n_reg; // mreq_n at last zneg
	logic                  fetch_stb;  // start of an opcode fetch

	assign sel      = cfg.pent1m_rom;
	assign sel_page = pages[sel];
	assign win_hit  = (bus.za[15:14] == window_index);

	// xxF7 writes into the map chosen by the current rom bit
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pages[0] <= 8'hFF;
			pages[1] <= 8'hFF;
			ramnrom  <= 2'b00;
			dos_7ffd <= 2'b00;
		end
		else if (f7_wr && win_hit)
		begin
			if (bus.za[mem_map_pkg::F7_1M_SEL_BIT]) // xFF7, 1m format
			begin
				pages[sel]    <= ~{2'b11, f7_data.mb1.page_n};
				ramnrom[sel]  <= f7_data.mb1.ramnrom;
				dos_7ffd[sel] <= f7_data.mb1.dos_7ffd;
			end
			else // x7F7, 4m ram, dos_7ffd kept
			begin
				pages[sel]   <= ~f7_data.mb4;
				ramnrom[sel] <= 1'b1;
			end
		end
	end

	// page selection, forced cases first
	always_comb
	begin
		map_next.page    = sel_page;
		map_next.romnram = ~ramnrom[sel];
		map_next.valid   = 1'b1;

		if (pager_off)
		begin
			map_next.page    = mem_map_pkg::SERVICE_ROM_PAGE;
			map_next.romnram = 1'b1;
			map_next.valid   = 1'b0;
		end
		else if ((window_index == 2'd0) && in_nmi) // nmi beats ram0
		begin
			map_next.page    = mem_map_pkg::NMI_RAM_PAGE;
			map_next.romnram = 1'b0;
			map_next.valid   = 1'b0;
		end
		else if ((window_index == 2'd0) && cfg.pent1m_ram0_0)
		begin
			map_next.page    = mem_map_pkg::RAM0_PAGE;
			map_next.romnram = 1'b0;
			map_next.valid   = 1'b0;
		end
		else if (dos_7ffd[sel])
		begin
			if (ramnrom[sel] && cfg.pent1m_1m_on)
				map_next.page = {sel_page[7:6], cfg.pent1m_page}; // whole 1m from 7ffd
			else if (ramnrom[sel])
				map_next.page = {sel_page[7:3], cfg.pent1m_page[2:0]}; // 128k
			else
				map_next.page = {sel_page[7:1], dos}; // basic/dos rom pair
		end
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
			map <= '{page: 8'hFF, romnram: 1'b1, valid: 1'b0};
		else
			map <= map_next;
	end

	assign rd_back.page0    = pages[0];
	assign rd_back.page1    = pages[1];
	assign rd_back.dos_7ffd = dos_7ffd;
	assign rd_back.ramnrom  = ramnrom;

	// m1 settles before zpos, mreq falls around zneg
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			m1_n_reg   <= 1'b1;
			mreq_n_reg <= 1'b1;
		end
		else
		begin
			if (phase.zpos)
				m1_n_reg <= bus.m1_n;
			if (phase.zneg)
				mreq_n_reg <= bus.mreq_n;
		end
	end

	assign fetch_stb = phase.zneg && !m1_n_reg && !bus.mreq_n && mreq_n_reg;

	// entry is tracked by window 0 only, for any address below c000
	assign dos_turn_on = (window_index == 2'd0) && fetch_stb && !(&bus.za[15:14]) &&
		(bus.za[13:8] == mem_map_pkg::DOS_ENTRY_HI) && cfg.pent1m_rom;

	// exit on any fetch at 4000 and up, each window flags its own range
	assign dos_turn_off = (window_index != 2'd0) && fetch_stb && win_hit;

endmodule

// ==== pager/pager_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank of four window pagers
// keeps the trdos flag and the z80 clock
// stall after dos entry, and muxes the
// mapping and xxBE read-back of the
// addressed window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pager_bank
(
	input  logic                   fclk,
	input  logic                   reset,

	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::z80_phase_t phase,
	input  mem_map_pkg::pent_cfg_t  cfg,
	input  logic                   f7_wr,
	input  mem_map_pkg::f7_data_u  f7_data,
	input  logic                   pager_off,
	input  logic                   in_nmi,

	output mem_map_pkg::map_t      mem_map,
	output mem_map_pkg::pager_rd_t rd_back,
	output logic                   dos,
	output logic                   zclk_stall
);

	mem_map_pkg::map_t     map_w [4];
	mem_map_pkg::pager_rd_t rd_w [4];
	logic [3:0]            turn_on_w;
	logic [3:0]            turn_off_w;

	logic                  dos_turn_on;
	logic                  dos_turn_off;
	logic [2:0]            stall_cnt; // remaining stall cycles after turn-on
	mem_map_pkg::window_t  win;

	for (genvar i = 0; i < 4; i++)
	begin : g_win
		atm_pager #(
			.window_index(mem_map_pkg::window_t'(i))
		) u_pager (
			.fclk        (fclk),
			.reset       (reset),
			.bus         (bus),
			.phase       (phase),
			.cfg         (cfg),
			.f7_wr       (f7_wr),
			.f7_data     (f7_data),
			.pager_off   (pager_off),
			.in_nmi      (in_nmi),
			.dos         (dos),
			.map         (map_w[i]),
			.rd_back     (rd_w[i]),
			.dos_turn_on (turn_on_w[i]),
			.dos_turn_off(turn_off_w[i])
		);
	end

	assign dos_turn_on  = |turn_on_w;  // only window 0 ever drives it
	assign dos_turn_off = |turn_off_w;

	always_ff @(posedge fclk)
	begin
		if (reset)
			dos <= 1'b0;
		else if (dos_turn_on) // entry wins over exit
			dos <= 1'b1;
		else if (dos_turn_off)
			dos <= 1'b0;
	end

	// give the rom chip time to deliver the new data
	always_ff @(posedge fclk)
	begin
		if (reset)
			stall_cnt <= 3'd0;
		else if (dos_turn_on)
			stall_cnt <= 3'(mem_map_pkg::STALL_CYCLES - 1);
		else if (stall_cnt != 3'd0)
			stall_cnt <= stall_cnt - 3'd1;
	end

	assign zclk_stall = dos_turn_on || (stall_cnt != 3'd0);

	assign win     = bus.za[15:14];
	assign mem_map = map_w[win];
	assign rd_back = rd_w[win];

endmodule

// ==== rtl/zports.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// z80 io write decoder for paging
// makes the xxF7 strobe and keeps the
// pentagon-1024 7ffd and eff7 latches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module zports
(
	input  logic                   fclk,
	input  logic                   reset,

	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::z80_phase_t phase,

	output logic                   f7_wr,   // one cycle, same edge as the latches
	output mem_map_pkg::f7_data_u  f7_data,
	output mem_map_pkg::pent_cfg_t cfg
);

	logic iorq_n_reg; // iorq_n at previous zpos
	logic io_wr_stb;  // first zpos of an io write cycle

	always_ff @(posedge fclk)
	begin
		if (reset)
			iorq_n_reg <= 1'b1;
		else if (phase.zpos)
			iorq_n_reg <= bus.iorq_n;
	end

	// iorq falling edge seen at zpos, wr already low then
	assign io_wr_stb = phase.zpos && !bus.iorq_n && !bus.wr_n && iorq_n_reg;

	assign f7_wr   = io_wr_stb && (bus.za[7:0] == mem_map_pkg::PORT_F7_LO);
	assign f7_data = bus.zd; // pager picks the format by za[11]

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cfg <= '0;
		end
		else if (io_wr_stb)
		begin
			if (bus.za == mem_map_pkg::PORT_7FFD)
			begin
				// pentagon-1024 page bits d5,d7,d6,d2..d0
				cfg.pent1m_page <= {bus.zd[5], bus.zd[7:6], bus.zd[2:0]};
				cfg.pent1m_rom  <= bus.zd[4];
			end
			if (bus.za == mem_map_pkg::PORT_EFF7)
			begin
				cfg.pent1m_ram0_0 <= bus.zd[3];  // ram0 at 0000
				cfg.pent1m_1m_on  <= ~bus.zd[2]; // d2 low enables 1m mode
			end
		end
	end

endmodule

// ==== rtl/memory_pager_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory pager top level
// port decoder feeding the pager bank,
// gives the memory controller the page
// of the addressed window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module memory_pager_top
(
	input  logic                   fclk,
	input  logic                   reset,

	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::z80_phase_t phase,
	input  logic                   pager_off,
	input  logic                   in_nmi,

	output mem_map_pkg::map_t      mem_map,
	output mem_map_pkg::pager_rd_t rd_back,
	output logic                   dos,
	output logic                   zclk_stall // to the z80 clock generator
);

	logic                   f7_wr;
	mem_map_pkg::f7_data_u  f7_data;
	mem_map_pkg::pent_cfg_t cfg;

	zports u_zports (
		.fclk   (fclk),
		.reset  (reset),
		.bus    (bus),
		.phase  (phase),
		.f7_wr  (f7_wr),
		.f7_data(f7_data),
		.cfg    (cfg)
	);

	pager_bank u_bank (
		.fclk      (fclk),
		.reset     (reset),
		.bus       (bus),
		.phase     (phase),
		.cfg       (cfg),
		.f7_wr     (f7_wr),
		.f7_data   (f7_data),
		.pager_off (pager_off),
		.in_nmi    (in_nmi),
		.mem_map   (mem_map),
		.rd_back   (rd_back),
		.dos       (dos),
		.zclk_stall(zclk_stall)
	);

endmodule

// ==== verification/memory_pager_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the pager bank
// bound into pager_bank by the testbench,
// watch the stall length and dos strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module memory_pager_properties
(
	input logic                    fclk,
	input logic                    reset,
	input z80_bus_pkg::z80_phase_t phase,
	input logic                    dos_turn_on,
	input logic                    dos_turn_off,
	input logic                    dos,
	input logic                    zclk_stall
);

	logic [3:0] stall_len; // length of the running stall

	always_ff @(posedge fclk)
	begin
		if (reset)
			stall_len <= 4'd0;
		else if (zclk_stall)
			stall_len <= stall_len + 4'd1;
		else
			stall_len <= 4'd0;
	end

	// a stall run ends after exactly STALL_CYCLES
	a_stall_len: assert property (@(posedge fclk) disable iff (reset)
		(!zclk_stall && $past(zclk_stall)) |-> (stall_len == 4'(mem_map_pkg::STALL_CYCLES)))
		else $error("zclk_stall ran for %0d cycles", stall_len);

	// fetch strobes only on the z80 falling edge
	a_strobe_zneg: assert property (@(posedge fclk) disable iff (reset)
		(dos_turn_on || dos_turn_off) |-> phase.zneg)
		else $error("dos strobe outside a zneg cycle");

	a_dos_reset: assert property (@(posedge fclk) reset |=> !dos)
		else $error("dos set while in reset");

endmodule

// ==== verification/memory_pager_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory pager top level
// seeded random io writes and opcode fetches
// checked against a reference model of the
// page maps, the 7ffd/eff7 latches and dos
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module memory_pager_tb;

	localparam int N_RESET    = 3;
	localparam int N_WRITES   = 200; // random xxF7 writes
	localparam int N_CFG      = 60;  // 7ffd/eff7 rounds with dos_7ffd set
	localparam int N_PRIO     = 40;  // forced page rounds
	localparam int N_FETCH    = 80;  // random opcode fetches
	localparam int OP_CYCLES  = 48;  // upper bound of one test step
	localparam int MAX_CYCLES = 2 * (N_RESET +
		(N_WRITES + N_CFG + N_PRIO + N_FETCH + 8) * OP_CYCLES);

	logic                    fclk = 1'b0;
	logic                    reset;
	z80_bus_pkg::z80_bus_t   bus;
	z80_bus_pkg::z80_phase_t phase;
	logic                    pager_off;
	logic                    in_nmi;
	mem_map_pkg::map_t       mem_map;
	mem_map_pkg::pager_rd_t  rd_back;
	logic                    dos;
	logic                    zclk_stall;

	integer seed;
	int     cyc;            // driver cycle count, sets the phase strobes
	int     wd_cycles = 0;
	int     stall_seen;     // stall cycles since the last clear

	// reference model state
	mem_map_pkg::page_t     m_page [4][2]; // per window, per map
	logic [1:0]             m_ramnrom [4];
	logic [1:0]             m_dos7ffd [4];
	mem_map_pkg::pent_cfg_t m_cfg;
	logic                   m_dos;

	memory_pager_top i_memory_pager_top (
		.fclk      (fclk),
		.reset     (reset),
		.bus       (bus),
		.phase     (phase),
		.pager_off (pager_off),
		.in_nmi    (in_nmi),
		.mem_map   (mem_map),
		.rd_back   (rd_back),
		.dos       (dos),
		.zclk_stall(zclk_stall)
	);

	bind pager_bank memory_pager_properties u_props (
		.fclk        (fclk),
		.reset       (reset),
		.phase       (phase),
		.dos_turn_on (dos_turn_on),
		.dos_turn_off(dos_turn_off),
		.dos         (dos),
		.zclk_stall  (zclk_stall)
	);

	always #50 fclk = ~fclk; // 100 ns period

	always @(posedge fclk)
	begin
		wd_cycles = wd_cycles + 1;
		if (wd_cycles > MAX_CYCLES)
		begin
			$display("Test failures found");
			$fatal(1, "watchdog expired after %0d cycles", wd_cycles);
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic check_map(input mem_map_pkg::map_t got, input mem_map_pkg::map_t exp,
		input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_rd_back(input mem_map_pkg::pager_rd_t got,
		input mem_map_pkg::pager_rd_t exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// one fclk cycle, zpos and zneg each once in four cycles
	task automatic next_cycle();
		@(posedge fclk);
		if (zclk_stall === 1'b1) // level the dut flops see at this edge
			stall_seen = stall_seen + 1;
		@(negedge fclk);
		cyc = cyc + 1;
		phase.zpos = (cyc % 4 == 0);
		phase.zneg = (cyc % 4 == 2);
	endtask

	task automatic bus_idle();
		bus.mreq_n = 1'b1;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		bus.m1_n   = 1'b1;
	endtask

	// runs to a zpos cycle with the bus idle
	task automatic sync_zpos();
		bus_idle();
		next_cycle();
		while (phase.zpos !== 1'b1)
			next_cycle();
	endtask

	function automatic void model_io_write(input logic [15:0] addr, input logic [7:0] data);
		mem_map_pkg::window_t w;
		logic                 s;
		w = addr[15:14];
		s = m_cfg.pent1m_rom; // map in use before this write
		if (addr[7:0] == 8'hF7)
		begin
			if (addr[11]) // 1m format, top two page bits end up 0
			begin
				m_page[w][s]    = {2'b00, ~data[5:0]};
				m_ramnrom[w][s] = data[6];
				m_dos7ffd[w][s] = data[7];
			end
			else
			begin
				m_page[w][s]    = ~data;
				m_ramnrom[w][s] = 1'b1;
			end
		end
		if (addr == mem_map_pkg::PORT_7FFD)
		begin
			m_cfg.pent1m_page = {data[5], data[7], data[6], data[2:0]}; // pentagon-1024 order
			m_cfg.pent1m_rom  = data[4];
		end
		if (addr == mem_map_pkg::PORT_EFF7)
		begin
			m_cfg.pent1m_ram0_0 = data[3];
			m_cfg.pent1m_1m_on  = !data[2];
		end
	endfunction

	// later overrides have higher priority
	function automatic mem_map_pkg::map_t exp_map(input mem_map_pkg::window_t w);
		mem_map_pkg::map_t  m;
		mem_map_pkg::page_t p;
		logic               s;
		s = m_cfg.pent1m_rom;
		p = m_page[w][s];
		m.page    = p;
		m.romnram = !m_ramnrom[w][s];
		m.valid   = 1'b1;
		if (m_dos7ffd[w][s])
		begin
			if (!m_ramnrom[w][s])
				m.page = {p[7:1], m_dos};
			else if (m_cfg.pent1m_1m_on)
				m.page = {p[7:6], m_cfg.pent1m_page};
			else
				m.page = {p[7:3], m_cfg.pent1m_page[2:0]};
		end
		if (w == 2'd0 && m_cfg.pent1m_ram0_0)
			m = '{page: 8'h00, romnram: 1'b0, valid: 1'b0};
		if (w == 2'd0 && in_nmi)
			m = '{page: 8'hFF, romnram: 1'b0, valid: 1'b0};
		if (pager_off)
			m = '{page: 8'hFF, romnram: 1'b1, valid: 1'b0};
		return m;
	endfunction

	function automatic mem_map_pkg::pager_rd_t exp_rd(input mem_map_pkg::window_t w);
		mem_map_pkg::pager_rd_t r;
		r.page0    = m_page[w][1'b0];
		r.page1    = m_page[w][1'b1];
		r.dos_7ffd = m_dos7ffd[w];
		r.ramnrom  = m_ramnrom[w];
		return r;
	endfunction

	// iorq and wr low across one zpos, iorq high at the zpos before
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		sync_zpos();
		next_cycle();
		bus.za     = addr;
		bus.zd     = data;
		bus.iorq_n = 1'b0;
		bus.wr_n   = 1'b0;
		repeat (4) next_cycle();
		bus_idle();
		model_io_write(addr, data);
		next_cycle();
	endtask

	task automatic check_window(input mem_map_pkg::window_t w);
		bus.za = {w, 14'h0A55};
		next_cycle();
		check_map(mem_map, exp_map(w), $sformatf("mem_map[%0d]", w));
		check_rd_back(rd_back, exp_rd(w), $sformatf("rd_back[%0d]", w));
	endtask

	task automatic check_all_windows();
		for (int w = 0; w < 4; w++)
			check_window(2'(w));
	endtask

	// m1 low at a zpos, then mreq falls before the next zneg
	task automatic opcode_fetch(input logic [15:0] addr);
		logic on;
		logic off;
		on  = (addr[15:14] != 2'b11) && (addr[13:8] == 6'h3D) && m_cfg.pent1m_rom;
		off = (addr[15:14] != 2'b00);
		sync_zpos();
		next_cycle();
		bus.za   = addr;
		bus.m1_n = 1'b0;
		repeat (4) next_cycle();
		bus.mreq_n = 1'b0;
		bus.rd_n   = 1'b0;
		stall_seen = 0;
		repeat (3) next_cycle(); // zneg of the fetch is the first of these
		bus_idle();
		repeat (6) next_cycle();
		if (on)
			m_dos = 1'b1; // entry beats exit
		else if (off)
			m_dos = 1'b0;
		check_bit(dos, m_dos, "dos");
		check_count(stall_seen, on ? mem_map_pkg::STALL_CYCLES : 0, "zclk_stall length");
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] d;
		logic [15:0] addr;

		seed       = 82215;
		cyc        = 0;
		stall_seen = 0;
		reset      = 1'b1;
		bus        = '0;
		bus_idle();
		phase      = '0;
		pager_off  = 1'b0;
		in_nmi     = 1'b0;
		m_page     = '{default: 8'hFF};
		m_ramnrom  = '{default: 2'b00};
		m_dos7ffd  = '{default: 2'b00};
		m_cfg      = '0;
		m_dos      = 1'b0;

		repeat (N_RESET) next_cycle();
		reset = 1'b0;

		// reset state
		check_all_windows();
		check_bit(dos, 1'b0, "dos");
		check_bit(zclk_stall, 1'b0, "zclk_stall");

		// random xxF7 writes, map selection flipped now and then
		for (int i = 0; i < N_WRITES; i++)
		begin
			r = rand_word();
			if (r[1:0] == 2'b00)
				io_write(mem_map_pkg::PORT_7FFD, r[15:8]);
			r = rand_word();
			addr = {r[15:8], 8'hF7};
			io_write(addr, r[23:16]);
			check_window(addr[15:14]);
		end

		// 1m writes with dos_7ffd set, then new 7ffd and eff7 values
		for (int i = 0; i < N_CFG; i++)
		begin
			r = rand_word();
			io_write({r[15:8] | 8'h08, 8'hF7}, {1'b1, r[16], r[22:17]});
			io_write(mem_map_pkg::PORT_7FFD, r[31:24]);
			d = rand_word();
			io_write(mem_map_pkg::PORT_EFF7, {d[7:4], 1'b0, d[2:0]}); // ram0 stays off here
			check_all_windows();
		end

		// forced pages over the port maps
		for (int i = 0; i < N_PRIO; i++)
		begin
			r = rand_word();
			io_write(mem_map_pkg::PORT_EFF7, {4'h0, r[0], r[1], 2'b00});
			pager_off = (r[3:2] == 2'b00);
			in_nmi    = r[4];
			check_all_windows();
		end
		pager_off = 1'b0;
		in_nmi    = 1'b0;

		// dos entry and exit
		io_write(mem_map_pkg::PORT_7FFD, 8'h10);
		opcode_fetch(16'h3D2F);
		opcode_fetch(16'h8123);
		io_write(mem_map_pkg::PORT_7FFD, 8'h00);
		opcode_fetch(16'h3D00); // rom bit clear, nothing happens
		for (int i = 0; i < N_FETCH; i++)
		begin
			r = rand_word();
			if (r[0])
				io_write(mem_map_pkg::PORT_7FFD, r[15:8]);
			addr = r[4] ? {r[6:5], 6'h3D, r[31:24]} : r[31:16];
			opcode_fetch(addr);
			check_all_windows();
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== vlog.f ====
common/z80_bus_pkg.sv
common/mem_map_pkg.sv
pager/atm_pager.sv
pager/pager_bank.sv
rtl/zports.sv
rtl/memory_pager_top.sv
verification/memory_pager_properties.sv
verification/memory_pager_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory pager testbench

VERILATOR ?= verilator
TOP       := memory_pager_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
